// ==== design/rv32_params.svh ====
`ifndef RV32_PARAMS_SVH
`define RV32_PARAMS_SVH

// data path width
`define RV32_XLEN 32

// data memory depth in 32-bit words
`define RV32_DMEM_WORDS 256

// ****************************************
// access width codes
// ****************************************
`define RV32_MEM_WIDTH_WORD 2'd0
`define RV32_MEM_WIDTH_HALF 2'd1
`define RV32_MEM_WIDTH_BYTE 2'd2

// ****************************************
// branch op codes
// ****************************************
`define RV32_BRANCH_NEVER   2'd0
`define RV32_BRANCH_ZERO    2'd1
`define RV32_BRANCH_NONZERO 2'd2
`define RV32_BRANCH_ALWAYS  2'd3

`endif

// ==== design/rv32_pkg.sv ====
`include "rv32_params.svh"

package rv32_pkg;

    // one data word, also used for addresses and register values
    typedef logic [`RV32_XLEN-1:0] word_t;

    typedef logic [4:0] reg_addr_t; // x0..x31

    // ****************************************
    // encoded control fields
    // ****************************************
    typedef logic [1:0] mem_width_t; // RV32_MEM_WIDTH_* codes
    typedef logic [1:0] branch_op_t; // RV32_BRANCH_* codes

    // byte lane write mask, bit 3 is bits 31..24
    typedef logic [`RV32_XLEN/8-1:0] byte_mask_t;

endpackage

// ==== design/rv32_branch.sv ====
`include "rv32_params.svh"

module rv32_branch
    import rv32_pkg::*;
(
    input  branch_op_t op,
    input  word_t      result,
    output logic       taken
);

    logic result_zero;

    // execute leaves the compare encoded in the subtraction result
    assign result_zero = (result == '0);

    always_comb begin
        case (op)
            `RV32_BRANCH_NEVER:   taken = 1'b0;
            `RV32_BRANCH_ZERO:    taken = result_zero;
            `RV32_BRANCH_NONZERO: taken = !result_zero;
            `RV32_BRANCH_ALWAYS:  taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

endmodule

// ==== design/rv32_mem.sv ====
`include "rv32_params.svh"

module rv32_mem
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    // from hazard unit
    input  logic       stall,
    input  logic       flush,

    // control from execute
    input  logic       read,
    input  logic       write,
    input  mem_width_t width,
    input  logic       zero_extend,
    input  branch_op_t branch_op,
    input  reg_addr_t  rd,
    input  logic       rd_write,

    // data from execute
    input  word_t      result,
    input  word_t      rs2_value,
    input  word_t      branch_pc,

    // data memory read port
    input  word_t      read_value,

    // control out
    output logic       branch_taken,
    output reg_addr_t  rd_out,
    output logic       rd_write_out,

    // data memory control
    output logic       dmem_read,
    output byte_mask_t write_mask,

    // data out
    output word_t      rd_value_out,
    output word_t      branch_pc_out,

    // data memory address and write data
    output word_t      address,
    output word_t      write_value
);

    logic        store_en;
    logic [1:0]  offset;
    byte_mask_t  lane_mask;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_value;

    rv32_branch i_branch (
        .op     (branch_op),
        .result (result),
        .taken  (branch_taken)
    );

    assign branch_pc_out = branch_pc; // target passes straight to fetch
    assign dmem_read     = read;
    assign address       = result;
    assign offset        = result[1:0];

    // a held or killed slot must not touch memory
    assign store_en   = write && !stall && !flush;
    assign write_mask = store_en ? lane_mask : '0;

    // ****************************************
    // store lane formatting
    // ****************************************
    always_comb begin
        write_value = '0; // unused lanes stay zero
        lane_mask   = '0;
        case (width)
            `RV32_MEM_WIDTH_WORD: begin
                write_value = rs2_value;
                lane_mask   = 4'b1111;
            end
            `RV32_MEM_WIDTH_HALF: begin
                if (offset[1]) begin
                    write_value[15:0] = rs2_value[15:0];
                    lane_mask         = 4'b0011;
                end else begin
                    write_value[31:16] = rs2_value[15:0];
                    lane_mask          = 4'b1100;
                end
            end
            `RV32_MEM_WIDTH_BYTE: begin
                case (offset)
                    2'd0: write_value[31:24] = rs2_value[7:0];
                    2'd1: write_value[23:16] = rs2_value[7:0];
                    2'd2: write_value[15:8]  = rs2_value[7:0];
                    default: write_value[7:0] = rs2_value[7:0];
                endcase
                lane_mask = 4'b1000 >> offset;
            end
            default: begin
                lane_mask = '0; // reserved code, no store
            end
        endcase
    end

    // ****************************************
    // load lane select and extension
    // ****************************************
    always_comb begin
        case (offset)
            2'd0: load_byte = read_value[31:24];
            2'd1: load_byte = read_value[23:16];
            2'd2: load_byte = read_value[15:8];
            default: load_byte = read_value[7:0];
        endcase
    end

    assign load_half = offset[1] ? read_value[15:0] : read_value[31:16];

    always_comb begin
        case (width)
            `RV32_MEM_WIDTH_HALF:
                load_value = {{16{!zero_extend && load_half[15]}}, load_half};
            `RV32_MEM_WIDTH_BYTE:
                load_value = {{24{!zero_extend && load_byte[7]}}, load_byte};
            default:
                load_value = read_value; // full word
        endcase
    end

    // writeback register, held under stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_out       <= '0;
            rd_write_out <= 1'b0;
            rd_value_out <= '0;
        end else if (!stall) begin
            rd_out       <= rd;
            rd_write_out <= rd_write && !flush; // flushed slot never writes back
            rd_value_out <= read ? load_value : result;
        end
    end

endmodule

// ==== design/rv32_dmem.sv ====
`include "rv32_params.svh"

module rv32_dmem
    import rv32_pkg::*;
#(
    parameter int DEPTH = `RV32_DMEM_WORDS
) (
    input  logic       clk,
    input  logic       arst_n,
    input  word_t      addr,
    input  byte_mask_t wmask,
    input  word_t      wdata,
    output word_t      rdata
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t            mem [DEPTH];
    logic [IDX_W-1:0] idx;

    // word index, wraps at DEPTH
    assign idx   = IDX_W'(addr[`RV32_XLEN-1:2] % DEPTH);
    assign rdata = mem[idx];

    // simulation start value
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (arst_n) begin // nothing lands while in reset
            for (int b = 0; b < `RV32_XLEN/8; b++) begin
                if (wmask[b]) begin
                    mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== design/rv32_regfile.sv ====
module rv32_regfile
    import rv32_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // write port
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,

    // read port
    input  reg_addr_t rd_addr,
    output word_t     rd_data
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass, a write shows after its edge
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// ==== design/rv32_mem_subsys.sv ====
module rv32_mem_subsys
    import rv32_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    // hazard unit
    input  logic       stall,
    input  logic       flush,

    // ****************************************
    // execute stage
    // ****************************************
    input  logic       read,
    input  logic       write,
    input  mem_width_t width,
    input  logic       zero_extend,
    input  branch_op_t branch_op,
    input  reg_addr_t  rd,
    input  logic       rd_write,
    input  word_t      result,
    input  word_t      rs2_value,
    input  word_t      branch_pc,

    input  reg_addr_t  rs_addr, // register file read index

    // to fetch
    output logic       branch_taken,
    output word_t      branch_pc_next,

    // forwarding and writeback
    output reg_addr_t  rd_out,
    output logic       rd_write_out,
    output word_t      rd_value_out,

    output word_t      rs_value
);

    // data memory side
    word_t      dmem_addr;
    byte_mask_t dmem_wmask;
    word_t      dmem_wdata;
    word_t      dmem_rdata;

    rv32_mem i_mem (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .flush         (flush),
        .read          (read),
        .write         (write),
        .width         (width),
        .zero_extend   (zero_extend),
        .branch_op     (branch_op),
        .rd            (rd),
        .rd_write      (rd_write),
        .result        (result),
        .rs2_value     (rs2_value),
        .branch_pc     (branch_pc),
        .read_value    (dmem_rdata),
        .branch_taken  (branch_taken),
        .rd_out        (rd_out),
        .rd_write_out  (rd_write_out),
        .dmem_read     (), // memory reads every cycle
        .write_mask    (dmem_wmask),
        .rd_value_out  (rd_value_out),
        .branch_pc_out (branch_pc_next),
        .address       (dmem_addr),
        .write_value   (dmem_wdata)
    );

    rv32_dmem i_dmem (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (dmem_addr),
        .wmask  (dmem_wmask),
        .wdata  (dmem_wdata),
        .rdata  (dmem_rdata)
    );

    // writeback triple drives the write port directly
    rv32_regfile i_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr_addr (rd_out),
        .wr_en   (rd_write_out),
        .wr_data (rd_value_out),
        .rd_addr (rs_addr),
        .rd_data (rs_value)
    );

endmodule

// ==== verification/rv32_mem_subsys_assert.sv ====
`include "rv32_params.svh"

module rv32_mem_subsys_assert
    import rv32_pkg::*;
#(
    parameter int DEPTH = `RV32_DMEM_WORDS
) (
    input logic       clk,
    input logic       arst_n,
    input logic       stall,
    input logic       flush,
    input logic       read,
    input logic       write,
    input mem_width_t width,
    input logic       zero_extend,
    input branch_op_t branch_op,
    input reg_addr_t  rd,
    input logic       rd_write,
    input word_t      result,
    input word_t      rs2_value,
    input word_t      branch_pc,
    input reg_addr_t  rs_addr,
    input logic       branch_taken,
    input word_t      branch_pc_next,
    input reg_addr_t  rd_out,
    input logic       rd_write_out,
    input word_t      rd_value_out,
    input word_t      rs_value,
    input byte_mask_t dmem_wmask,
    input word_t      dmem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        error_seen = 1'b0;
    word_t       shadow [DEPTH];
    word_t       sregs [32];
    int unsigned widx;
    word_t       shadow_word;
    byte_mask_t  exp_mask;
    logic        exp_taken;
    reg_addr_t   exp_rd;
    logic        exp_we;
    word_t       exp_val;
    word_t       exp_rs;

    // offset 0 sits in lane 3, the top byte
    function automatic byte_mask_t store_lanes(mem_width_t w, logic [1:0] off);
        byte_mask_t m;
        int         sz;
        m  = '0;
        sz = (w == `RV32_MEM_WIDTH_WORD) ? 2 : (w == `RV32_MEM_WIDTH_HALF) ? 1 : 0;
        if (w > `RV32_MEM_WIDTH_BYTE) return m;
        for (int b = 0; b < 4; b++) begin
            if (((3 - b) >> sz) == (int'(off) >> sz)) m[b] = 1'b1;
        end
        return m;
    endfunction

    function automatic word_t extend_lane(word_t w, mem_width_t wd, logic [1:0] off,
                                          logic zext);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> ((3 - off) * 8));
        h = 16'(w >> ((1 - off[1]) * 16));
        if (wd == `RV32_MEM_WIDTH_BYTE) return zext ? {24'd0, b} : {{24{b[7]}}, b};
        if (wd == `RV32_MEM_WIDTH_HALF) return zext ? {16'd0, h} : {{16{h[15]}}, h};
        return w;
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) shadow[i] = '0;
    end

    assign widx        = result[31:2] % DEPTH;
    assign shadow_word = shadow[widx];
    assign exp_mask    = store_lanes(width, result[1:0]);
    assign exp_rs      = (rs_addr == '0) ? '0 : sregs[rs_addr];
    assign exp_taken   = (branch_op == `RV32_BRANCH_ALWAYS) ||
                         (branch_op == `RV32_BRANCH_ZERO && result == '0) ||
                         (branch_op == `RV32_BRANCH_NONZERO && result != '0);

    // ****************************************
    // reference model of memory and writeback
    // ****************************************
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) sregs[i] <= '0;
            exp_rd  <= '0;
            exp_we  <= 1'b0;
            exp_val <= '0;
        end else begin
            if (write && !stall && !flush) begin
                for (int b = 0; b < 4; b++) begin
                    if (exp_mask[b])
                        shadow[widx][b*8 +: 8] <= 8'(rs2_value >> ((b % 2) * 8 *
                            ((width == `RV32_MEM_WIDTH_HALF) ? 1 : 0) +
                            ((width == `RV32_MEM_WIDTH_WORD) ? b * 8 : 0)));
                end
            end
            if (!stall) begin
                exp_rd  <= rd;
                exp_we  <= rd_write && !flush;
                exp_val <= read ? extend_lane(shadow_word, width, result[1:0], zero_extend)
                                : result;
            end
            if (exp_we && exp_rd != '0) sregs[exp_rd] <= exp_val;
        end
    end

    a_reset: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
                              !rd_write_out && rd_value_out == '0)
        else begin
            $error("** Error @ %0t: rd_write_out/rd_value_out expected 0 actual %b/%h",
                   $time, rd_write_out, rd_value_out);
            error_seen = 1'b1;
        end
    a_taken: assert property (@(posedge clk) disable iff (!arst_n) branch_taken == exp_taken)
        else begin
            $error("** Error @ %0t: branch_taken expected %b actual %b",
                   $time, exp_taken, branch_taken);
            error_seen = 1'b1;
        end
    a_pc: assert property (@(posedge clk) disable iff (!arst_n) branch_pc_next == branch_pc)
        else begin
            $error("** Error @ %0t: branch_pc_next expected %h actual %h",
                   $time, branch_pc, branch_pc_next);
            error_seen = 1'b1;
        end
    a_no_write: assert property (@(posedge clk) disable iff (!arst_n)
                                 (stall || flush) |-> dmem_wmask == '0)
        else begin
            $error("** Error @ %0t: dmem_wmask expected 0 actual %b",
                   $time, dmem_wmask);
            error_seen = 1'b1;
        end
    a_mem: assert property (@(posedge clk) disable iff (!arst_n) dmem_rdata == shadow_word)
        else begin
            $error("** Error @ %0t: dmem_rdata expected %h actual %h",
                   $time, shadow_word, dmem_rdata);
            error_seen = 1'b1;
        end
    a_wb_val: assert property (@(posedge clk) disable iff (!arst_n) rd_value_out == exp_val)
        else begin
            $error("** Error @ %0t: rd_value_out expected %h actual %h",
                   $time, exp_val, rd_value_out);
            error_seen = 1'b1;
        end
    a_wb_we: assert property (@(posedge clk) disable iff (!arst_n) rd_write_out == exp_we)
        else begin
            $error("** Error @ %0t: rd_write_out expected %b actual %b",
                   $time, exp_we, rd_write_out);
            error_seen = 1'b1;
        end
    a_wb_rd: assert property (@(posedge clk) disable iff (!arst_n) rd_out == exp_rd)
        else begin
            $error("** Error @ %0t: rd_out expected %0d actual %0d",
                   $time, exp_rd, rd_out);
            error_seen = 1'b1;
        end
    a_stall: assert property (@(posedge clk) disable iff (!arst_n) stall |=>
                              $stable(rd_value_out) && $stable(rd_write_out) && $stable(rd_out))
        else begin
            $error("registered outputs changed during a stall");
            error_seen = 1'b1;
        end
    a_flush: assert property (@(posedge clk) disable iff (!arst_n)
                              (flush && !stall) |=> !rd_write_out)
        else begin
            $error("** Error @ %0t: rd_write_out expected 0 actual %b",
                   $time, rd_write_out);
            error_seen = 1'b1;
        end
    a_rs: assert property (@(posedge clk) disable iff (!arst_n) rs_value == exp_rs)
        else begin
            $error("** Error @ %0t: rs_value expected %h actual %h",
                   $time, exp_rs, rs_value);
            error_seen = 1'b1;
        end

endmodule

bind rv32_mem_subsys rv32_mem_subsys_assert i_assert (.*);

// ==== verification/rv32_mem_subsys_tb.sv ====
`include "rv32_params.svh"

module rv32_mem_subsys_tb
    import rv32_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_CYCLES   = 400;
    localparam int CYCLE_LIMIT     = (DIRECTED_CYCLES + RANDOM_CYCLES) * 2;

    logic       clk;
    logic       arst_n;
    logic       stall;
    logic       flush;
    logic       read;
    logic       write;
    mem_width_t width;
    logic       zero_extend;
    branch_op_t branch_op;
    reg_addr_t  rd;
    logic       rd_write;
    word_t      result;
    word_t      rs2_value;
    word_t      branch_pc;
    reg_addr_t  rs_addr;
    logic       branch_taken;
    word_t      branch_pc_next;
    reg_addr_t  rd_out;
    logic       rd_write_out;
    word_t      rd_value_out;
    word_t      rs_value;
    integer     seed;
    int         cycles;

    rv32_mem_subsys i_rv32_mem_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display(">>> FAIL");
            $fatal(1, "timeout after %0d cycles", cycles);
        end
    end

    // stop at the first failing assertion
    initial begin
        wait (i_rv32_mem_subsys.i_assert.error_seen);
        $display(">>> FAIL");
        $fatal(1, "assertion failed");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_idle();
        stall     = 1'b0;
        flush     = 1'b0;
        read      = 1'b0;
        write     = 1'b0;
        rd_write  = 1'b0;
        rd        = '0;
        branch_op = `RV32_BRANCH_NEVER;
    endtask

    task automatic store(mem_width_t w, word_t addr, word_t data);
        set_idle();
        write     = 1'b1;
        width     = w;
        result    = addr;
        rs2_value = data;
        next_cycle();
    endtask

    task automatic load(mem_width_t w, word_t addr, logic zext, reg_addr_t dst);
        set_idle();
        read        = 1'b1;
        width       = w;
        result      = addr;
        zero_extend = zext;
        rd          = dst;
        rd_write    = 1'b1;
        next_cycle();
    endtask

    task automatic alu_write(reg_addr_t dst, word_t value);
        set_idle();
        rd       = dst;
        rd_write = 1'b1;
        result   = value;
        rs_addr  = dst;
        next_cycle();
    endtask

    initial begin
        seed        = 85763;
        cycles      = 0;
        arst_n      = 1'b0;
        width       = `RV32_MEM_WIDTH_WORD;
        zero_extend = 1'b0;
        result      = '0;
        rs2_value   = '0;
        branch_pc   = 32'h0000_1000;
        rs_addr     = '0;
        set_idle();
        repeat (5) @(posedge clk);
        #1 arst_n = 1'b1;
        next_cycle();

        // branch ops against zero and nonzero results
        for (int op = 0; op < 4; op++) begin
            set_idle();
            branch_op = branch_op_t'(op);
            branch_pc = 32'h0000_2000 + op * 4;
            result    = '0;
            next_cycle();
            result    = 32'h0000_0010 << op;
            next_cycle();
        end

        // ****************************************
        // stores at every width and offset
        // ****************************************
        store(`RV32_MEM_WIDTH_WORD, 32'h40, 32'h8122_a344);
        store(`RV32_MEM_WIDTH_HALF, 32'h44, 32'h0000_f00d);
        store(`RV32_MEM_WIDTH_HALF, 32'h46, 32'h0000_8eef);
        for (int off = 0; off < 4; off++) begin
            store(`RV32_MEM_WIDTH_BYTE, 32'h48 + off, 32'h80 + off * 17);
        end
        store(`RV32_MEM_WIDTH_BYTE, 32'h41, 32'h0000_00c5);
        store(`RV32_MEM_WIDTH_HALF, 32'h4e, 32'h0000_7abc);

        // stores held off by stall and by flush
        stall = 1'b1;
        write = 1'b1;
        next_cycle();
        stall = 1'b0;
        flush = 1'b1;
        next_cycle();

        // loads at every width, offset and extension
        for (int a = 32'h40; a < 32'h50; a++) begin
            load(`RV32_MEM_WIDTH_BYTE, a, 1'b0, 5'd3);
            load(`RV32_MEM_WIDTH_BYTE, a, 1'b1, 5'd4);
            if (a % 2 == 0) begin
                load(`RV32_MEM_WIDTH_HALF, a, 1'b0, 5'd6);
                load(`RV32_MEM_WIDTH_HALF, a, 1'b1, 5'd7);
            end
            if (a % 4 == 0) load(`RV32_MEM_WIDTH_WORD, a, 1'b0, 5'd8);
        end

        // held outputs while inputs keep moving
        load(`RV32_MEM_WIDTH_WORD, 32'h40, 1'b0, 5'd9);
        for (int i = 0; i < 4; i++) begin
            stall    = 1'b1;
            result   = 32'h100 + i;
            rd       = 5'(i + 10);
            rd_write = 1'b1;
            next_cycle();
        end
        set_idle();
        rd_write = 1'b1;
        rd       = 5'd12;
        flush    = 1'b1;
        next_cycle();

        // register file round trip, x0 stays zero
        alu_write(5'd5, 32'hdead_beef);
        alu_write(5'd0, 32'h1234_5678);
        set_idle();
        rs_addr = 5'd5;
        repeat (2) next_cycle();
        rs_addr = 5'd0;
        repeat (2) next_cycle();

        // ****************************************
        // random traffic
        // ****************************************
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            stall       = ($random(seed) % 8) == 0;
            flush       = ($random(seed) % 8) == 0;
            read        = 1'($random(seed));
            write       = 1'($random(seed));
            width       = mem_width_t'(($random(seed) & 32'h7fff_ffff) % 3);
            zero_extend = 1'($random(seed));
            branch_op   = branch_op_t'($random(seed));
            rd          = reg_addr_t'($random(seed));
            rd_write    = 1'($random(seed));
            result      = ($random(seed) % 4 == 0) ? '0 : ($random(seed) & 32'h7f);
            rs2_value   = $random(seed);
            branch_pc   = $random(seed);
            rs_addr     = reg_addr_t'($random(seed));
            next_cycle();
        end
        set_idle();
        repeat (3) next_cycle();

        if (i_rv32_mem_subsys.i_assert.error_seen) begin
            $display(">>> FAIL");
            $fatal(1, "assertion failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== rv32_mem_subsys.f ====
+incdir+design
design/rv32_pkg.sv
design/rv32_branch.sv
design/rv32_mem.sv
design/rv32_dmem.sv
design/rv32_regfile.sv
design/rv32_mem_subsys.sv
verification/rv32_mem_subsys_assert.sv
verification/rv32_mem_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory-access subsystem

VERILATOR ?= verilator
FILELIST  ?= rv32_mem_subsys.f
TB_TOP    ?= rv32_mem_subsys_tb
RTL_TOP   ?= rv32_mem_subsys
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) -Idesign \
		design/rv32_pkg.sv design/rv32_branch.sv design/rv32_mem.sv \
		design/rv32_dmem.sv design/rv32_regfile.sv design/rv32_mem_subsys.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
